//--- list.f
+incdir+design
design/wm_pkg.sv
design/wm_inst_decode.sv
design/wm_weight_bank.sv
design/wm_read_port.sv
design/weight_manager.sv
test/tb_weight_manager.sv

//--- Bender.yml
package:
  name: weight_manager

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/wm_pkg.sv
      - design/wm_inst_decode.sv
      - design/wm_weight_bank.sv
      - design/wm_read_port.sv
      - design/weight_manager.sv

  - target: test
    include_dirs:
      - design
    files:
      - test/tb_weight_manager.sv

//--- test/tb_weight_manager.sv
`include "wm_settings.svh"

`default_nettype none

module tb_weight_manager;
    import wm_pkg::*;

    localparam int w_max = (1 << (`WM_BITWIDTH - 1)) - 1;
    localparam int w_min = -(1 << (`WM_BITWIDTH - 1));

    logic    clk;
    logic    rst_n;
    data_t   data;
    inst_t   inst;
    logic    exec;
    weight_t read_reg;
    weight_t weights [`WM_WIDTH-1:0][`WM_DEPTH-1:0];

    // Reference grid and the one command waiting to be applied.
    weight_t ref_grid [`WM_WIDTH-1:0][`WM_DEPTH-1:0];
    logic    pend_valid;
    inst_t   pend_inst;
    data_t   pend_data;
    weight_t exp_read;

    weight_t    snap [`WM_WIDTH-1:0][`WM_DEPTH-1:0];
    depth_idx_t inc_depth;
    weight_t    old_val;
    weight_t    new_val;
    int         value;
    integer     seed;
    int         errors;

    weight_manager UUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .data     (data),
        .inst     (inst),
        .exec     (exec),
        .read_reg (read_reg),
        .weights  (weights)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic inst_t make_inst(input op_e op, input lane_idx_t lane,
                                        input depth_idx_t depth);
        return {op, lane, depth};
    endfunction

    // Model of one command taking effect on the grid.
    task automatic apply_ref(input inst_t cmd, input data_t dt);
        int v;
        if (cmd.op == op_load) begin
            ref_grid[cmd.lane][cmd.depth] = weight_t'(dt[`WM_BITWIDTH-1:0]);
        end else begin
            for (int l = 0; l < `WM_WIDTH; l++) begin
                v = int'(ref_grid[l][cmd.depth]) + int'($signed(dt[2*l +: 2]));
                if (v > w_max) begin
                    v = w_max; // Clamp high.
                end else if (v < w_min) begin
                    v = w_min;
                end
                ref_grid[l][cmd.depth] = weight_t'(v);
            end
        end
    endtask

    // Strobe captured at edge N, grid updated at edge N+1.
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < `WM_WIDTH; l++) begin
                for (int d = 0; d < `WM_DEPTH; d++) begin
                    ref_grid[l][d] = '0;
                end
            end
            pend_valid = 1'b0;
            exp_read   = '0;
        end else begin
            exp_read = ref_grid[inst.lane][inst.depth]; // Grid before this edge.
            if (pend_valid) begin
                apply_ref(pend_inst, pend_data);
            end
            pend_valid = exec;
            pend_inst  = inst;
            pend_data  = data;
        end
    end

    property read_matches_ref;
        @(posedge clk) disable iff (!rst_n) read_reg == exp_read;
    endproperty

    read_check: assert property (read_matches_ref) else begin
        errors++;
        $display("[ERROR] %0t: read_reg is %0d, expected %0d",
                 $time, $sampled(read_reg), $sampled(exp_read));
    end

    // Called at a falling edge, returns at the next one.
    task automatic send_cmd(input op_e op, input lane_idx_t lane, input depth_idx_t depth,
                            input data_t dt);
        inst = make_inst(op, lane, depth);
        data = dt;
        exec = 1'b1;
        @(negedge clk);
        exec = 1'b0;
    endtask

    task automatic wait_settled();
        int cycles;
        cycles = 0;
        while (pend_valid && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        if (pend_valid) begin
            errors++;
            $display("Timeout: a command was still pending after %0d cycles at time %0t",
                     cycles, $time);
        end
    endtask

    task automatic check_grid(input string what);
        for (int l = 0; l < `WM_WIDTH; l++) begin
            for (int d = 0; d < `WM_DEPTH; d++) begin
                assert (weights[l][d] == ref_grid[l][d]) else begin
                    errors++;
                    $display("[ERROR] %0t: %s, weights[%0d][%0d] is %0d, expected %0d",
                             $time, what, l, d, weights[l][d], ref_grid[l][d]);
                end
            end
        end
    endtask

    task automatic check_read(input weight_t expected, input string what);
        assert (read_reg == expected) else begin
            errors++;
            $display("[ERROR] %0t: %s, read_reg is %0d, expected %0d",
                     $time, what, read_reg, expected);
        end
    endtask

    initial begin
        seed   = 18973;
        errors = 0;
        rst_n  = 1'b0;
        exec   = 1'b0;
        inst   = '0;
        data   = '0;

        repeat (5) @(negedge clk);
        check_grid("during reset");
        check_read('0, "during reset");
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_grid("after reset");
        check_read('0, "after reset");

        // Random load into every entry.
        for (int l = 0; l < `WM_WIDTH; l++) begin
            for (int d = 0; d < `WM_DEPTH; d++) begin
                send_cmd(op_load, lane_idx_t'(l), depth_idx_t'(d), data_t'($random(seed)));
                wait_settled();
                check_grid("load");
            end
        end

        // Read sweep, checked by the property.
        for (int l = 0; l < `WM_WIDTH; l++) begin
            for (int d = 0; d < `WM_DEPTH; d++) begin
                inst = make_inst(op_load, lane_idx_t'(l), depth_idx_t'(d));
                @(negedge clk);
            end
        end
        @(negedge clk);

        // Increments with random steps.
        repeat (8) begin
            inc_depth = depth_idx_t'($random(seed));
            snap = weights;
            send_cmd(op_increment, lane_idx_t'($random(seed)), inc_depth,
                     data_t'($random(seed)));
            wait_settled();
            check_grid("increment");
            for (int l = 0; l < `WM_WIDTH; l++) begin
                for (int d = 0; d < `WM_DEPTH; d++) begin
                    if (d != inc_depth) begin
                        assert (weights[l][d] == snap[l][d]) else begin
                            errors++;
                            $display("[ERROR] %0t: increment at depth %0d changed [%0d][%0d]",
                                     $time, inc_depth, l, d);
                        end
                    end
                end
            end
        end

        // Near the limits, even lanes climb and odd lanes fall.
        for (int l = 0; l < `WM_WIDTH; l++) begin
            value = (l % 2 == 0) ? w_max - 2 : w_min + 2;
            send_cmd(op_load, lane_idx_t'(l), depth_idx_t'(5), data_t'(weight_t'(value)));
        end
        wait_settled();
        check_grid("saturation preload");
        repeat (5) begin
            send_cmd(op_increment, '0, depth_idx_t'(5), 32'h9999_9999); // +1 / -2 steps.
            wait_settled();
            check_grid("saturating increment");
        end
        for (int l = 0; l < `WM_WIDTH; l++) begin
            value = (l % 2 == 0) ? w_max : w_min;
            assert (weights[l][5] == weight_t'(value)) else begin
                errors++;
                $display("[ERROR] %0t: lane %0d did not stop at %0d, holds %0d",
                         $time, l, value, weights[l][5]);
            end
        end

        // Back to back on one depth.
        repeat (4) begin
            for (int k = 0; k < 6; k++) begin
                send_cmd((k % 2 == 1) ? op_increment : op_load, lane_idx_t'($random(seed)),
                         depth_idx_t'(2), data_t'($random(seed)));
            end
            wait_settled();
            check_grid("back-to-back");
        end

        // Read and write of one entry at the same edge.
        old_val = ref_grid[9][4];
        new_val = old_val ^ 8'h5a;
        send_cmd(op_load, lane_idx_t'(9), depth_idx_t'(4), data_t'(new_val));
        @(negedge clk);
        check_read(old_val, "same-edge read");
        @(negedge clk);
        check_read(new_val, "read after write");
        check_grid("same-edge write");

        @(negedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/weight_manager.sv
`include "wm_settings.svh"

`default_nettype none

module weight_manager (
    input  wire logic           clk,
    input  wire logic           rst_n,
    input  wire wm_pkg::data_t  data,
    input  wire wm_pkg::inst_t  inst,
    input  wire logic           exec,
    output wm_pkg::weight_t     read_reg,
    output wm_pkg::weight_t     weights [`WM_WIDTH-1:0][`WM_DEPTH-1:0]
);
    import wm_pkg::*;

    logic       cmd_load;
    logic       cmd_inc;
    lane_idx_t  cmd_lane;
    depth_idx_t cmd_depth;
    weight_t    cmd_value;
    step_t      cmd_steps [`WM_WIDTH-1:0];

    // Read address follows inst on every edge.
    lane_idx_t  rd_lane;
    depth_idx_t rd_depth;

    assign rd_lane  = inst.lane;
    assign rd_depth = inst.depth;

    wm_inst_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .exec      (exec),
        .inst      (inst),
        .data      (data),
        .cmd_load  (cmd_load),
        .cmd_inc   (cmd_inc),
        .cmd_lane  (cmd_lane),
        .cmd_depth (cmd_depth),
        .cmd_value (cmd_value),
        .cmd_steps (cmd_steps)
    );

    wm_weight_bank u_bank (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_load  (cmd_load),
        .cmd_inc   (cmd_inc),
        .cmd_lane  (cmd_lane),
        .cmd_depth (cmd_depth),
        .cmd_value (cmd_value),
        .cmd_steps (cmd_steps),
        .weights   (weights)
    );

    wm_read_port u_read (
        .clk      (clk),
        .rst_n    (rst_n),
        .lane     (rd_lane),
        .depth    (rd_depth),
        .weights  (weights),
        .read_reg (read_reg)
    );

endmodule

`default_nettype wire

//--- design/wm_read_port.sv
`include "wm_settings.svh"

`default_nettype none

module wm_read_port (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire wm_pkg::lane_idx_t  lane,
    input  wire wm_pkg::depth_idx_t depth,
    input  wire wm_pkg::weight_t    weights [`WM_WIDTH-1:0][`WM_DEPTH-1:0],
    output wm_pkg::weight_t         read_reg
);
    import wm_pkg::*;

    weight_t lane_col [`WM_DEPTH-1:0];
    weight_t sel;

    // Lane first, then depth.
    always_comb begin
        for (int d = 0; d < `WM_DEPTH; d++) begin
            lane_col[d] = weights[lane][d];
        end
        sel = lane_col[depth];
    end

    // Sampled every cycle, old grid value on a same-edge write.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_reg <= '0;
        end else begin
            read_reg <= sel;
        end
    end

endmodule

`default_nettype wire

//--- design/wm_weight_bank.sv
`include "wm_settings.svh"

`default_nettype none

module wm_weight_bank (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               cmd_load,
    input  wire logic               cmd_inc,
    input  wire wm_pkg::lane_idx_t  cmd_lane,
    input  wire wm_pkg::depth_idx_t cmd_depth,
    input  wire wm_pkg::weight_t    cmd_value,
    input  wire wm_pkg::step_t      cmd_steps [`WM_WIDTH-1:0],
    output wm_pkg::weight_t         weights [`WM_WIDTH-1:0][`WM_DEPTH-1:0]
);
    import wm_pkg::*;

    // Saturation limits of the weight range.
    localparam weight_t weight_max = weight_t'({1'b0, {(`WM_BITWIDTH-1){1'b1}}});
    localparam weight_t weight_min = weight_t'({1'b1, {(`WM_BITWIDTH-1){1'b0}}});

    weight_t grid [`WM_WIDTH-1:0][`WM_DEPTH-1:0];

    // One extra bit so the raw sum cannot wrap.
    logic signed [`WM_BITWIDTH:0] sum [`WM_WIDTH-1:0];
    weight_t                      inc_result [`WM_WIDTH-1:0];

    always_comb begin
        for (int l = 0; l < `WM_WIDTH; l++) begin
            sum[l] = grid[l][cmd_depth] + cmd_steps[l]; // Sign extended.
            if (sum[l] > weight_max) begin
                inc_result[l] = weight_max;
            end else if (sum[l] < weight_min) begin
                inc_result[l] = weight_min;
            end else begin
                inc_result[l] = weight_t'(sum[l][`WM_BITWIDTH-1:0]);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int l = 0; l < `WM_WIDTH; l++) begin
                for (int d = 0; d < `WM_DEPTH; d++) begin
                    grid[l][d] <= '0;
                end
            end
        end else if (cmd_load) begin
            grid[cmd_lane][cmd_depth] <= cmd_value;
        end else if (cmd_inc) begin
            // All lanes at one depth.
            for (int l = 0; l < `WM_WIDTH; l++) begin
                grid[l][cmd_depth] <= inc_result[l];
            end
        end
    end

    assign weights = grid;

endmodule

`default_nettype wire

//--- design/wm_inst_decode.sv
`include "wm_settings.svh"

`default_nettype none

module wm_inst_decode (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire logic               exec,
    input  wire wm_pkg::inst_t      inst,
    input  wire wm_pkg::data_t      data,
    output logic                    cmd_load,
    output logic                    cmd_inc,
    output wm_pkg::lane_idx_t       cmd_lane,
    output wm_pkg::depth_idx_t      cmd_depth,
    output wm_pkg::weight_t         cmd_value,
    output wm_pkg::step_t           cmd_steps [`WM_WIDTH-1:0]
);
    import wm_pkg::*;

    op_e        op;
    lane_idx_t  lane;
    depth_idx_t depth;
    weight_t    value;
    step_t      steps [`WM_WIDTH-1:0];

    // Instruction fields.
    assign op    = inst.op;
    assign lane  = inst.lane;
    assign depth = inst.depth;

    // Load value sits in the low bits of data.
    assign value = weight_t'(data[`WM_BITWIDTH-1:0]);

    always_comb begin
        for (int i = 0; i < `WM_WIDTH; i++) begin
            steps[i] = $signed(data[2*i +: 2]); // Lane i step.
        end
    end

    // Exactly one pulse per strobe.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_load <= 1'b0;
            cmd_inc  <= 1'b0;
        end else begin
            cmd_load <= exec && (op == op_load);
            cmd_inc  <= exec && (op == op_increment);
        end
    end

    // Payload held until the next strobe.
    always_ff @(posedge clk) begin
        if (exec) begin
            cmd_lane  <= lane;
            cmd_depth <= depth;
            cmd_value <= value;
            for (int i = 0; i < `WM_WIDTH; i++) begin
                cmd_steps[i] <= steps[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- design/wm_pkg.sv
`default_nettype none

`include "wm_settings.svh"

package wm_pkg;

    // Top bit of the instruction word.
    typedef enum logic {
        op_load      = 1'b0,
        op_increment = 1'b1
    } op_e;

    typedef logic signed [`WM_BITWIDTH-1:0] weight_t;

    // Covers -2 to +1.
    typedef logic signed [1:0] step_t;

    typedef logic [$clog2(`WM_WIDTH)-1:0] lane_idx_t;
    typedef logic [$clog2(`WM_DEPTH)-1:0] depth_idx_t;

    // Operation on top, depth index in the low bits.
    typedef struct packed {
        op_e        op;
        lane_idx_t  lane;
        depth_idx_t depth;
    } inst_t;

    // Two bits per lane, lane 0 at the bottom.
    typedef logic [`WM_WIDTH*2-1:0] data_t;

endpackage

`default_nettype wire

//--- design/wm_settings.svh
`ifndef WM_SETTINGS_SVH
`define WM_SETTINGS_SVH

// Number of lanes in the grid.
`define WM_WIDTH 16

// Depth entries per lane.
`define WM_DEPTH 8

// Bits per signed weight.
`define WM_BITWIDTH 8

`endif
